/* Bender.yml */
package:
  name: csr_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/csr_unit_pkg.sv
      - logic/csr_access_ctrl.sv
      - logic/csr_trap_regs.sv
      - logic/csr_perf_counters.sv
      - logic/csr_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/csr_unit_tb.sv

/* csr_unit.f */
+incdir+logic
logic/csr_unit_pkg.sv
logic/csr_access_ctrl.sv
logic/csr_trap_regs.sv
logic/csr_perf_counters.sv
logic/csr_unit.sv
verification/csr_unit_tb.sv

/* logic/csr_access_ctrl.sv */
// CSR access handshake FSM, set/clear merge, write strobe and read-data register
`timescale 1ns/10ps
`default_nettype none
`include "csr_unit_defines.svh"

module csr_access_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  // host side, four-phase req/ack
  input  logic                   csr_req_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_unit_pkg::csr_op_e  csr_op_i,
  input  logic [`CSR_DATA_W-1:0] csr_wdata_i,
  // read data of the register blocks
  input  logic [`CSR_DATA_W-1:0] trap_rdata_i,
  input  logic [`CSR_DATA_W-1:0] perf_rdata_i,
  // towards the register blocks
  output logic [`CSR_ADDR_W-1:0] csr_addr_o,
  output logic                   csr_we_o,
  output logic [`CSR_DATA_W-1:0] csr_wdata_o,
  output logic                   csr_ack_o,
  output logic [`CSR_DATA_W-1:0] csr_rdata_o
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  logic                   start;
  logic [`CSR_DATA_W-1:0] cur_rdata;
  logic [`CSR_DATA_W-1:0] rdata_q;

  // only the owning block returns nonzero data
  assign cur_rdata = trap_rdata_i | perf_rdata_i;

  // first sampled cycle of req
  assign start = (state_q == ST_IDLE) & csr_req_i;

  //////////////////////////////////////////////////////////////////////
  // handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (csr_req_i) begin
          state_d = ST_ACK;
        end
      end
      // hold ack until the host lets go of req
      ST_ACK: begin
        if (!csr_req_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // old value, taken at the same edge that commits the write
  always_ff @(posedge clk) begin
    if (start) begin
      rdata_q <= cur_rdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // operation merge
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_wdata_o = csr_wdata_i;
    case (csr_op_i)
      csr_unit_pkg::SET:   csr_wdata_o = cur_rdata | csr_wdata_i;
      csr_unit_pkg::CLEAR: csr_wdata_o = cur_rdata & ~csr_wdata_i;
      default:             csr_wdata_o = csr_wdata_i;
    endcase
  end

  // one strobe per access, a no-op only reads
  assign csr_we_o    = start & (csr_op_i != csr_unit_pkg::NONE);
  assign csr_addr_o  = csr_addr_i;
  assign csr_ack_o   = (state_q == ST_ACK);
  assign csr_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* logic/csr_perf_counters.sv */
// performance event qualification, PCCR counters, PCER/PCMR and counter read data
`timescale 1ns/10ps
`default_nettype none
`include "csr_unit_defines.svh"

module csr_perf_counters (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic                   csr_we_i,
  input  logic [`CSR_DATA_W-1:0] csr_wdata_i,
  // pipeline events
  input  logic                   id_valid_i,
  input  logic                   is_decoding_i,
  input  logic                   ld_stall_i,
  input  logic                   jr_stall_i,
  input  logic                   imiss_i,
  input  logic                   pc_set_i,
  input  logic                   mem_load_i,
  input  logic                   mem_store_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i,
  output logic [`CSR_DATA_W-1:0] rdata_o
);

  // pccr block spans 32 addresses from the base
  localparam int unsigned BLK_W = 5;
  localparam int unsigned IDX_W = $clog2(`CSR_N_PERF);
  localparam logic [`CSR_ADDR_W-1:0] PCCR_BASE = `CSR_ADDR_PCCR_BASE;

  logic                                    id_valid_q;
  logic [`CSR_N_PERF-1:0]                  events;
  logic [`CSR_N_PERF-1:0]                  inc;
  logic [`CSR_N_PERF-1:0]                  inc_q;
  logic [`CSR_N_PERF-1:0]                  pcer_q;
  logic [1:0]                              pcmr_q;
  logic [`CSR_N_PERF-1:0][`CSR_DATA_W-1:0] cnt_q;
  logic [`CSR_N_PERF-1:0]                  cnt_wr;
  logic [BLK_W-1:0]                        pccr_idx;
  logic                                    pccr_valid;
  logic                                    pccr_all;

  //////////////////////////////////////////////////////////////////////
  // event qualification
  //////////////////////////////////////////////////////////////////////

  assign events[0] = 1'b1;
  assign events[1] = id_valid_i & is_decoding_i;
  // stalls only count once the stalled instruction leaves ID
  assign events[2] = ld_stall_i & id_valid_q;
  assign events[3] = jr_stall_i & id_valid_q;
  // fetch misses after a jump or branch are not counted
  assign events[4] = imiss_i & ~pc_set_i;
  assign events[5] = mem_load_i;
  assign events[6] = mem_store_i;
  assign events[7] = branch_i & branch_taken_i & id_valid_q;

  // per-counter enable and global enable
  assign inc = events & pcer_q & {`CSR_N_PERF{pcmr_q[0]}};

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  assign pccr_idx   = csr_addr_i[BLK_W-1:0];
  assign pccr_all   = (csr_addr_i == `CSR_ADDR_PCCR_ALL);
  // 0x79f falls in the block but past the last counter
  assign pccr_valid = (csr_addr_i[`CSR_ADDR_W-1:BLK_W] == PCCR_BASE[`CSR_ADDR_W-1:BLK_W]) &
                      (pccr_idx < `CSR_N_PERF);

  always_comb begin
    for (int i = 0; i < `CSR_N_PERF; i++) begin
      cnt_wr[i] = csr_we_i & (pccr_all | (pccr_valid & (pccr_idx == i)));
    end
  end

  always_comb begin
    rdata_o = '0;
    if (csr_addr_i == `CSR_ADDR_PCER) begin
      rdata_o[`CSR_N_PERF-1:0] = pcer_q;
    end else if (csr_addr_i == `CSR_ADDR_PCMR) begin
      rdata_o[1:0] = pcmr_q;
    end else if (pccr_valid) begin
      rdata_o = cnt_q[pccr_idx[IDX_W-1:0]];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= `CSR_PCMR_RESET;
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      if (csr_we_i && (csr_addr_i == `CSR_ADDR_PCER)) begin
        pcer_q <= csr_wdata_i[`CSR_N_PERF-1:0];
      end
      if (csr_we_i && (csr_addr_i == `CSR_ADDR_PCMR)) begin
        pcmr_q <= csr_wdata_i[1:0];
      end
    end
  end

  // a CSR write beats the pending increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < `CSR_N_PERF; i++) begin
        if (cnt_wr[i]) begin
          cnt_q[i] <= csr_wdata_i;
        end else if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1])) begin
          // stuck at all ones when saturating, else wraps
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/csr_trap_regs.sv */
// machine trap CSRs, trap entry and MRET, hart ID and trap read data
`timescale 1ns/10ps
`default_nettype none
`include "csr_unit_defines.svh"

module csr_trap_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  // CSR write port from the access control
  input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  logic                    csr_we_i,
  input  logic [`CSR_DATA_W-1:0]  csr_wdata_i,
  input  logic [3:0]              core_id_i,
  input  logic [5:0]              cluster_id_i,
  // exception controller, single-cycle pulses
  input  logic                    save_exc_cause_i,
  input  logic [`CSR_CAUSE_W-1:0] exc_cause_i,
  input  logic                    data_load_event_ex_i,
  input  logic                    exc_save_if_i,
  input  logic                    exc_save_id_i,
  input  logic                    exc_save_takenbranch_i,
  input  logic [`CSR_DATA_W-1:0]  pc_if_i,
  input  logic [`CSR_DATA_W-1:0]  pc_id_i,
  input  logic [`CSR_DATA_W-1:0]  pc_ex_i,
  input  logic [`CSR_DATA_W-1:0]  branch_target_i,
  input  logic                    exc_restore_mret_i,
  output logic [`CSR_DATA_W-1:0]  rdata_o,
  output logic [`CSR_DATA_W-1:0]  epc_o,
  output logic [`CSR_DATA_W-1:0]  tvec_o,
  output logic                    irq_enable_o,
  output logic                    csr_busy_o
);

  csr_unit_pkg::mstatus_t  mstatus_q;
  csr_unit_pkg::mstatus_t  mstatus_d;
  logic [`CSR_DATA_W-1:0]  mepc_q;
  logic [`CSR_DATA_W-1:0]  mepc_d;
  logic [`CSR_CAUSE_W-1:0] mcause_q;
  logic [`CSR_CAUSE_W-1:0] mcause_d;
  logic [`CSR_TVEC_W-1:0]  mtvec_q;
  logic [`CSR_TVEC_W-1:0]  mtvec_d;
  logic [`CSR_DATA_W-1:0]  exception_pc;

  //////////////////////////////////////////////////////////////////////
  // read formats
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    case (csr_addr_i)
      `CSR_ADDR_MSTATUS: begin
        // mpp always reads as machine mode
        rdata_o[`CSR_MSTATUS_MPP_LSB +: 2] = 2'b11;
        rdata_o[`CSR_MSTATUS_MPIE_BIT]     = mstatus_q.mpie;
        rdata_o[`CSR_MSTATUS_MIE_BIT]      = mstatus_q.mie;
      end
      `CSR_ADDR_MTVEC: rdata_o = tvec_o;
      `CSR_ADDR_MEPC:  rdata_o = mepc_q;
      `CSR_ADDR_MCAUSE: begin
        // interrupt flag moves up to bit 31
        rdata_o[`CSR_DATA_W-1]    = mcause_q[`CSR_CAUSE_W-1];
        rdata_o[`CSR_CAUSE_W-2:0] = mcause_q[`CSR_CAUSE_W-2:0];
      end
      `CSR_ADDR_MHARTID: begin
        rdata_o[3:0]  = core_id_i;
        rdata_o[10:5] = cluster_id_i;
      end
      default: rdata_o = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // CSR writes, then trap entry and MRET on top
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;
    mtvec_d   = mtvec_q;

    if (csr_we_i) begin
      case (csr_addr_i)
        `CSR_ADDR_MSTATUS: begin
          mstatus_d.mie  = csr_wdata_i[`CSR_MSTATUS_MIE_BIT];
          mstatus_d.mpie = csr_wdata_i[`CSR_MSTATUS_MPIE_BIT];
        end
        `CSR_ADDR_MTVEC:  mtvec_d = csr_wdata_i[`CSR_DATA_W-1 -: `CSR_TVEC_W];
        `CSR_ADDR_MEPC:   mepc_d  = csr_wdata_i;
        `CSR_ADDR_MCAUSE: mcause_d = {csr_wdata_i[`CSR_DATA_W-1],
                                      csr_wdata_i[`CSR_CAUSE_W-2:0]};
        default: ;
      endcase
    end

    // exception pc, ID stage when nothing else is flagged
    if (data_load_event_ex_i) begin
      exception_pc = pc_ex_i;
    end else if (exc_save_if_i) begin
      exception_pc = pc_if_i;
    end else if (exc_save_id_i) begin
      exception_pc = pc_id_i;
    end else if (exc_save_takenbranch_i) begin
      exception_pc = branch_target_i;
    end else begin
      exception_pc = pc_id_i;
    end

    // trap entry wins over mret and over a CSR write
    if (save_exc_cause_i) begin
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = exception_pc;
      mcause_d       = exc_cause_i;
    end else if (exc_restore_mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtvec_q   <= `CSR_MTVEC_RESET;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
      mtvec_q   <= mtvec_d;
    end
  end

  // core side outputs straight from the registers
  assign epc_o        = mepc_q;
  assign tvec_o       = {mtvec_q, {(`CSR_DATA_W-`CSR_TVEC_W){1'b0}}};
  assign irq_enable_o = mstatus_q.mie;
  // stall the core while mepc or mtvec is being rewritten
  assign csr_busy_o   = csr_we_i & ((csr_addr_i == `CSR_ADDR_MTVEC) |
                                    (csr_addr_i == `CSR_ADDR_MEPC));

endmodule

`default_nettype wire

/* logic/csr_unit.sv */
// CSR unit top level, access control plus trap registers and performance counters
`timescale 1ns/10ps
`default_nettype none
`include "csr_unit_defines.svh"

module csr_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  // host CSR port
  input  logic                    csr_req_i,
  input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  csr_unit_pkg::csr_op_e   csr_op_i,
  input  logic [`CSR_DATA_W-1:0]  csr_wdata_i,
  output logic                    csr_ack_o,
  output logic [`CSR_DATA_W-1:0]  csr_rdata_o,
  input  logic [3:0]              core_id_i,
  input  logic [5:0]              cluster_id_i,
  // exception controller
  input  logic                    save_exc_cause_i,
  input  logic [`CSR_CAUSE_W-1:0] exc_cause_i,
  input  logic                    data_load_event_ex_i,
  input  logic                    exc_save_if_i,
  input  logic                    exc_save_id_i,
  input  logic                    exc_save_takenbranch_i,
  input  logic [`CSR_DATA_W-1:0]  pc_if_i,
  input  logic [`CSR_DATA_W-1:0]  pc_id_i,
  input  logic [`CSR_DATA_W-1:0]  pc_ex_i,
  input  logic [`CSR_DATA_W-1:0]  branch_target_i,
  input  logic                    exc_restore_mret_i,
  output logic [`CSR_DATA_W-1:0]  epc_o,
  output logic [`CSR_DATA_W-1:0]  tvec_o,
  output logic                    irq_enable_o,
  output logic                    csr_busy_o,
  // performance events
  input  logic                    id_valid_i,
  input  logic                    is_decoding_i,
  input  logic                    ld_stall_i,
  input  logic                    jr_stall_i,
  input  logic                    imiss_i,
  input  logic                    pc_set_i,
  input  logic                    mem_load_i,
  input  logic                    mem_store_i,
  input  logic                    branch_i,
  input  logic                    branch_taken_i
);

  // shared write port, read data back per block
  logic [`CSR_ADDR_W-1:0] csr_addr;
  logic                   csr_we;
  logic [`CSR_DATA_W-1:0] csr_wdata_int;
  logic [`CSR_DATA_W-1:0] trap_rdata;
  logic [`CSR_DATA_W-1:0] perf_rdata;

  csr_access_ctrl u_access_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req_i    (csr_req_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .csr_addr_o   (csr_addr),
    .csr_we_o     (csr_we),
    .csr_wdata_o  (csr_wdata_int),
    .csr_ack_o    (csr_ack_o),
    .csr_rdata_o  (csr_rdata_o)
  );

  csr_trap_regs u_trap_regs (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .csr_addr_i             (csr_addr),
    .csr_we_i               (csr_we),
    .csr_wdata_i            (csr_wdata_int),
    .core_id_i              (core_id_i),
    .cluster_id_i           (cluster_id_i),
    .save_exc_cause_i       (save_exc_cause_i),
    .exc_cause_i            (exc_cause_i),
    .data_load_event_ex_i   (data_load_event_ex_i),
    .exc_save_if_i          (exc_save_if_i),
    .exc_save_id_i          (exc_save_id_i),
    .exc_save_takenbranch_i (exc_save_takenbranch_i),
    .pc_if_i                (pc_if_i),
    .pc_id_i                (pc_id_i),
    .pc_ex_i                (pc_ex_i),
    .branch_target_i        (branch_target_i),
    .exc_restore_mret_i     (exc_restore_mret_i),
    .rdata_o                (trap_rdata),
    .epc_o                  (epc_o),
    .tvec_o                 (tvec_o),
    .irq_enable_o           (irq_enable_o),
    .csr_busy_o             (csr_busy_o)
  );

  csr_perf_counters u_perf_counters (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr),
    .csr_we_i       (csr_we),
    .csr_wdata_i    (csr_wdata_int),
    .id_valid_i     (id_valid_i),
    .is_decoding_i  (is_decoding_i),
    .ld_stall_i     (ld_stall_i),
    .jr_stall_i     (jr_stall_i),
    .imiss_i        (imiss_i),
    .pc_set_i       (pc_set_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .rdata_o        (perf_rdata)
  );

endmodule

`default_nettype wire

/* logic/csr_unit_defines.svh */
// widths, CSR addresses, mstatus bit positions and reset values of the CSR unit
`ifndef CSR_UNIT_DEFINES_SVH
`define CSR_UNIT_DEFINES_SVH

// datapath widths
`define CSR_ADDR_W 12
`define CSR_DATA_W 32
// msb of the cause flags an interrupt
`define CSR_CAUSE_W 6
// stored trap-vector bits, low byte reads as zero
`define CSR_TVEC_W 24
`define CSR_N_PERF 8

// machine trap CSRs
`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MTVEC 12'h305
`define CSR_ADDR_MEPC 12'h341
`define CSR_ADDR_MCAUSE 12'h342
`define CSR_ADDR_MHARTID 12'hF14

// performance counter block
`define CSR_ADDR_PCER 12'h7A0
`define CSR_ADDR_PCMR 12'h7A1
`define CSR_ADDR_PCCR_ALL 12'h79F
`define CSR_ADDR_PCCR_BASE 12'h780

// mstatus field positions
`define CSR_MSTATUS_MIE_BIT 3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_LSB 11

// pcmr: bit 0 global enable, bit 1 saturate
`define CSR_PCMR_RESET 2'h3
`define CSR_MTVEC_RESET 24'h0

`endif

/* logic/csr_unit_pkg.sv */
// CSR operation encoding and machine status register type
`default_nettype none

package csr_unit_pkg;

  // operation requested with each access
  // encoding matches the core decoder
  typedef enum logic [1:0] {
    NONE  = 2'b00,
    WRITE = 2'b01,
    SET   = 2'b10,
    CLEAR = 2'b11
  } csr_op_e;

  // stored mstatus bits
  // mpp is fixed to machine mode and not kept
  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

endpackage

`default_nettype wire

/* verification/csr_unit_tb.sv */
// CSR unit testbench with clock, reset, access table, trap and counter checks and summary
`timescale 1ns/10ps
`default_nettype none
`include "csr_unit_defines.svh"

module csr_unit_tb;

  localparam int unsigned TIMEOUT_CYC = 20;
  localparam int unsigned N_TBL       = 16;
  localparam logic [3:0]  CORE_ID     = 4'h5;
  localparam logic [5:0]  CLUSTER_ID  = 6'h2A;
  // mpp always reads as machine mode
  localparam logic [31:0] MPP_BITS    = 32'h3 << `CSR_MSTATUS_MPP_LSB;
  localparam logic [31:0] MIE_MASK    = 32'h1 << `CSR_MSTATUS_MIE_BIT;
  localparam logic [31:0] MPIE_MASK   = 32'h1 << `CSR_MSTATUS_MPIE_BIT;
  // address no block owns
  localparam logic [11:0] ADDR_UNMAPPED = 12'h123;

  logic                  clk;
  logic                  rst_n;
  logic                  csr_req;
  logic [11:0]           csr_addr;
  csr_unit_pkg::csr_op_e csr_op;
  logic [31:0]           csr_wdata;
  logic                  csr_ack;
  logic [31:0]           csr_rdata;
  logic                  save_exc_cause;
  logic [5:0]            exc_cause;
  logic                  data_load_event_ex;
  logic                  exc_save_if;
  logic                  exc_save_id;
  logic                  exc_save_takenbranch;
  logic [31:0]           pc_if;
  logic [31:0]           pc_id;
  logic [31:0]           pc_ex;
  logic [31:0]           branch_target;
  logic                  exc_restore_mret;
  logic [31:0]           epc;
  logic [31:0]           tvec;
  logic                  irq_enable;
  logic                  csr_busy;
  logic                  id_valid;
  logic                  is_decoding;
  logic                  ld_stall;
  logic                  jr_stall;
  logic                  imiss;
  logic                  pc_set;
  logic                  mem_load;
  logic                  mem_store;
  logic                  branch;
  logic                  branch_taken;

  int unsigned error_cnt;
  int unsigned timeout_cnt;
  int unsigned n_loads;
  logic [31:0] rd;
  logic        busy_seen;
  logic        busy_exp;

  // access table of address, op, write data, expected old value and state after
  logic [11:0]           tbl_addr [0:N_TBL-1];
  csr_unit_pkg::csr_op_e tbl_op [0:N_TBL-1];
  logic [31:0]           tbl_wdata [0:N_TBL-1];
  logic [31:0]           tbl_exp [0:N_TBL-1];
  logic [31:0]           tbl_epc [0:N_TBL-1];
  logic [31:0]           tbl_tvec [0:N_TBL-1];
  int unsigned           n_entries;

  csr_unit UUT (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .csr_req_i              (csr_req),
    .csr_addr_i             (csr_addr),
    .csr_op_i               (csr_op),
    .csr_wdata_i            (csr_wdata),
    .csr_ack_o              (csr_ack),
    .csr_rdata_o            (csr_rdata),
    .core_id_i              (CORE_ID),
    .cluster_id_i           (CLUSTER_ID),
    .save_exc_cause_i       (save_exc_cause),
    .exc_cause_i            (exc_cause),
    .data_load_event_ex_i   (data_load_event_ex),
    .exc_save_if_i          (exc_save_if),
    .exc_save_id_i          (exc_save_id),
    .exc_save_takenbranch_i (exc_save_takenbranch),
    .pc_if_i                (pc_if),
    .pc_id_i                (pc_id),
    .pc_ex_i                (pc_ex),
    .branch_target_i        (branch_target),
    .exc_restore_mret_i     (exc_restore_mret),
    .epc_o                  (epc),
    .tvec_o                 (tvec),
    .irq_enable_o           (irq_enable),
    .csr_busy_o             (csr_busy),
    .id_valid_i             (id_valid),
    .is_decoding_i          (is_decoding),
    .ld_stall_i             (ld_stall),
    .jr_stall_i             (jr_stall),
    .imiss_i                (imiss),
    .pc_set_i               (pc_set),
    .mem_load_i             (mem_load),
    .mem_store_i            (mem_store),
    .branch_i               (branch),
    .branch_taken_i         (branch_taken)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference rules and checks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] merge_op(input logic [31:0] old,
                                           input csr_unit_pkg::csr_op_e op,
                                           input logic [31:0] wdata);
    case (op)
      csr_unit_pkg::WRITE: merge_op = wdata;
      csr_unit_pkg::SET:   merge_op = old | wdata;
      csr_unit_pkg::CLEAR: merge_op = old & ~wdata;
      default:             merge_op = old;
    endcase
  endfunction

  // saturating counters stick at all ones and others wrap
  function automatic logic [31:0] expected_count(input logic [31:0] start,
                                                 input int unsigned n,
                                                 input logic saturate);
    logic [31:0] v;
    v = start;
    for (int unsigned k = 0; k < n; k++) begin
      if (!(saturate && (v == 32'hFFFF_FFFF))) begin
        v = v + 1;
      end
    end
    return v;
  endfunction

  task automatic compare_values(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    if (got !== exp) begin
      error_cnt = error_cnt + 1;
      $display("ERR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // full req/ack cycle starting and ending 2 ns after a rising edge
  task automatic csr_access(input logic [11:0] addr, input csr_unit_pkg::csr_op_e op,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic busy);
    int unsigned cyc;
    rdata     = '0;
    csr_addr  = addr;
    csr_op    = op;
    csr_wdata = wdata;
    csr_req   = 1'b1;
    // strobe cycle lies before the next edge
    #1;
    busy = csr_busy;
    cyc  = 0;
    @(posedge clk);
    #2;
    while (!csr_ack && (cyc < TIMEOUT_CYC)) begin
      @(posedge clk);
      #2;
      cyc = cyc + 1;
    end
    if (!csr_ack) begin
      timeout_cnt = timeout_cnt + 1;
      $display("timeout: ack did not rise within %0d cycles, address %h", TIMEOUT_CYC, addr);
    end else begin
      rdata = csr_rdata;
      compare_values("extra cycles before ack", cyc, 0);
    end
    csr_req = 1'b0;
    cyc     = 0;
    @(posedge clk);
    #2;
    while (csr_ack && (cyc < TIMEOUT_CYC)) begin
      @(posedge clk);
      #2;
      cyc = cyc + 1;
    end
    if (csr_ack) begin
      timeout_cnt = timeout_cnt + 1;
      $display("timeout: ack did not fall within %0d cycles, address %h", TIMEOUT_CYC, addr);
    end
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                            input string what);
    logic [31:0] v;
    logic        b;
    csr_access(addr, csr_unit_pkg::NONE, $urandom, v, b);
    compare_values(what, v, exp);
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] v;
    logic        b;
    csr_access(addr, csr_unit_pkg::WRITE, data, v, b);
  endtask

  //////////////////////////////////////////////////////////////////////
  // access table
  //////////////////////////////////////////////////////////////////////

  task automatic push_entry(input logic [11:0] addr, input csr_unit_pkg::csr_op_e op,
                            input logic [31:0] wdata, input logic [31:0] exp,
                            input logic [31:0] epc_after, input logic [31:0] tvec_after);
    tbl_addr[n_entries]  = addr;
    tbl_op[n_entries]    = op;
    tbl_wdata[n_entries] = wdata;
    tbl_exp[n_entries]   = exp;
    tbl_epc[n_entries]   = epc_after;
    tbl_tvec[n_entries]  = tvec_after;
    n_entries = n_entries + 1;
  endtask

  task automatic build_table;
    csr_unit_pkg::csr_op_e ops [0:4];
    logic [31:0]           epc_m;
    logic [31:0]           tvec_m;
    logic [31:0]           wd;
    logic [31:0]           nxt;
    ops = '{csr_unit_pkg::WRITE, csr_unit_pkg::SET, csr_unit_pkg::CLEAR,
            csr_unit_pkg::NONE, csr_unit_pkg::NONE};
    // both registers are zero out of reset
    epc_m     = '0;
    tvec_m    = '0;
    n_entries = 0;
    for (int i = 0; i < 5; i++) begin
      wd  = $urandom;
      nxt = merge_op(epc_m, ops[i], wd);
      push_entry(`CSR_ADDR_MEPC, ops[i], wd, epc_m, nxt, tvec_m);
      epc_m = nxt;
    end
    // only the upper 24 bits of mtvec are kept
    for (int i = 0; i < 5; i++) begin
      wd  = $urandom;
      nxt = merge_op(tvec_m, ops[i], wd) & 32'hFFFF_FF00;
      push_entry(`CSR_ADDR_MTVEC, ops[i], wd, tvec_m, epc_m, nxt);
      tvec_m = nxt;
    end
    push_entry(ADDR_UNMAPPED, csr_unit_pkg::WRITE, $urandom, 32'h0, epc_m, tvec_m);
    push_entry(ADDR_UNMAPPED, csr_unit_pkg::NONE, $urandom, 32'h0, epc_m, tvec_m);
    // cluster id at bits 10:5 and core id at 3:0
    push_entry(`CSR_ADDR_MHARTID, csr_unit_pkg::NONE, $urandom,
               {21'b0, CLUSTER_ID, 1'b0, CORE_ID}, epc_m, tvec_m);
  endtask

  //////////////////////////////////////////////////////////////////////
  // trap entry and MRET for sources EX (0), IF (1), ID (2) and branch (3)
  //////////////////////////////////////////////////////////////////////

  task automatic trap_and_return(input int src, input logic [5:0] cause);
    logic [31:0] pcs [0:3];
    for (int k = 0; k < 4; k++) begin
      pcs[k] = $urandom & 32'hFFFF_FFFC;
    end
    pc_ex                = pcs[0];
    pc_if                = pcs[1];
    pc_id                = pcs[2];
    branch_target        = pcs[3];
    exc_cause            = cause;
    save_exc_cause       = 1'b1;
    data_load_event_ex   = (src == 0);
    exc_save_if          = (src == 1);
    exc_save_id          = (src == 2);
    exc_save_takenbranch = (src == 3);
    @(posedge clk);
    #2;
    save_exc_cause       = 1'b0;
    data_load_event_ex   = 1'b0;
    exc_save_if          = 1'b0;
    exc_save_id          = 1'b0;
    exc_save_takenbranch = 1'b0;
    compare_values("irq_enable_o after trap entry", irq_enable, 1'b0);
    read_check(`CSR_ADDR_MEPC, pcs[src], $sformatf("mepc after trap, source %0d", src));
    // interrupt flag at bit 31 and code in the low bits
    read_check(`CSR_ADDR_MCAUSE, {cause[5], 26'b0, cause[4:0]}, "mcause after trap");
    read_check(`CSR_ADDR_MSTATUS, MPP_BITS | MPIE_MASK, "mstatus after trap");
    exc_restore_mret = 1'b1;
    @(posedge clk);
    #2;
    exc_restore_mret = 1'b0;
    compare_values("irq_enable_o after mret", irq_enable, 1'b1);
    compare_values("epc_o after mret", epc, pcs[src]);
    read_check(`CSR_ADDR_MSTATUS, MPP_BITS | MPIE_MASK | MIE_MASK, "mstatus after mret");
  endtask

  // loads and stores for n cycles then idle long enough for the count to land
  task automatic drive_mem_events(input int unsigned n);
    mem_load  = 1'b1;
    mem_store = 1'b1;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
    mem_load  = 1'b0;
    mem_store = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #2;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    error_cnt            = 0;
    timeout_cnt          = 0;
    void'($urandom(3618));
    rst_n                = 1'b0;
    csr_req              = 1'b0;
    csr_addr             = '0;
    csr_op               = csr_unit_pkg::NONE;
    csr_wdata            = '0;
    save_exc_cause       = 1'b0;
    exc_cause            = '0;
    data_load_event_ex   = 1'b0;
    exc_save_if          = 1'b0;
    exc_save_id          = 1'b0;
    exc_save_takenbranch = 1'b0;
    pc_if                = '0;
    pc_id                = '0;
    pc_ex                = '0;
    branch_target        = '0;
    exc_restore_mret     = 1'b0;
    id_valid             = 1'b0;
    is_decoding          = 1'b0;
    ld_stall             = 1'b0;
    jr_stall             = 1'b0;
    imiss                = 1'b0;
    pc_set               = 1'b0;
    mem_load             = 1'b0;
    mem_store            = 1'b0;
    branch               = 1'b0;
    branch_taken         = 1'b0;
    repeat (4) begin
      @(posedge clk);
    end
    #2;
    rst_n = 1'b1;

    // reset values
    compare_values("csr_ack_o after reset", csr_ack, 1'b0);
    compare_values("csr_busy_o after reset", csr_busy, 1'b0);
    compare_values("irq_enable_o after reset", irq_enable, 1'b0);
    read_check(`CSR_ADDR_MSTATUS, MPP_BITS, "mstatus after reset");
    read_check(`CSR_ADDR_MCAUSE, 32'h0, "mcause after reset");
    read_check(`CSR_ADDR_MEPC, 32'h0, "mepc after reset");
    read_check(`CSR_ADDR_PCMR, 32'h3, "pcmr after reset");
    read_check(`CSR_ADDR_PCER, 32'h0, "pcer after reset");

    // operation table on mepc, mtvec, an unmapped address and mhartid
    build_table();
    for (int i = 0; i < n_entries; i++) begin
      csr_access(tbl_addr[i], tbl_op[i], tbl_wdata[i], rd, busy_seen);
      busy_exp = (tbl_op[i] != csr_unit_pkg::NONE) &&
                 ((tbl_addr[i] == `CSR_ADDR_MEPC) || (tbl_addr[i] == `CSR_ADDR_MTVEC));
      compare_values($sformatf("read data of entry %0d", i), rd, tbl_exp[i]);
      compare_values($sformatf("csr_busy_o of entry %0d", i), busy_seen, busy_exp);
      compare_values($sformatf("epc_o after entry %0d", i), epc, tbl_epc[i]);
      compare_values($sformatf("tvec_o after entry %0d", i), tvec, tbl_tvec[i]);
    end

    // trap entry from each PC source with mie set
    write_csr(`CSR_ADDR_MSTATUS, MIE_MASK);
    compare_values("irq_enable_o after mie write", irq_enable, 1'b1);
    trap_and_return(0, 6'h05);
    trap_and_return(1, 6'h01);
    trap_and_return(2, 6'h02);
    trap_and_return(3, 6'h2B);

    // every counter runs for a while so the clear below has work to do
    write_csr(`CSR_ADDR_PCER, 32'hFF);
    // loads counter only and all counters cleared
    write_csr(`CSR_ADDR_PCER, 32'h1 << 5);
    write_csr(`CSR_ADDR_PCCR_ALL, 32'h0);
    n_loads = 5 + ($urandom % 12);
    drive_mem_events(n_loads);
    read_check(`CSR_ADDR_PCCR_BASE + 12'd5, expected_count(32'h0, n_loads, 1'b1),
               "loads counter");
    read_check(`CSR_ADDR_PCCR_BASE + 12'd0, 32'h0, "disabled cycles counter");
    read_check(`CSR_ADDR_PCCR_BASE + 12'd6, 32'h0, "disabled stores counter");

    // saturate first and wrap after
    write_csr(`CSR_ADDR_PCCR_BASE + 12'd5, 32'hFFFF_FFFE);
    drive_mem_events(5);
    read_check(`CSR_ADDR_PCCR_BASE + 12'd5, expected_count(32'hFFFF_FFFE, 5, 1'b1),
               "saturating loads counter");
    write_csr(`CSR_ADDR_PCMR, 32'h1);
    write_csr(`CSR_ADDR_PCCR_BASE + 12'd5, 32'hFFFF_FFFE);
    drive_mem_events(5);
    read_check(`CSR_ADDR_PCCR_BASE + 12'd5, expected_count(32'hFFFF_FFFE, 5, 1'b0),
               "wrapping loads counter");

    $display("errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
    if ((error_cnt == 0) && (timeout_cnt == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
